// ==== common/fetch_pkg.sv ====
`default_nettype none
//////////////////////////////////////////////////////////////////////
// fetch widths, opcode and funct3 constants
// instruction, parcel and compressed format types
//////////////////////////////////////////////////////////////////////

package fetch_pkg;

  parameter int XLEN             = 32;
  parameter int PARCEL_W         = 16;
  parameter int PARCELS_PER_WORD = XLEN / PARCEL_W;

  typedef logic [XLEN-1:0]     insn_t;
  typedef logic [PARCEL_W-1:0] parcel_t;

  // base opcodes
  parameter logic [6:0] OPC_LOAD   = 7'b0000011;
  parameter logic [6:0] OPC_STORE  = 7'b0100011;
  parameter logic [6:0] OPC_OP     = 7'b0110011;
  parameter logic [6:0] OPC_OP_IMM = 7'b0010011;
  parameter logic [6:0] OPC_LUI    = 7'b0110111;
  parameter logic [6:0] OPC_BRANCH = 7'b1100011;
  parameter logic [6:0] OPC_JAL    = 7'b1101111;
  parameter logic [6:0] OPC_JALR   = 7'b1100111;
  parameter logic [6:0] OPC_SYSTEM = 7'b1110011;

  // funct3 values
  parameter logic [2:0] F3_ADD = 3'b000; // add/sub/addi/jalr
  parameter logic [2:0] F3_SLL = 3'b001;
  parameter logic [2:0] F3_W   = 3'b010; // lw, sw
  parameter logic [2:0] F3_XOR = 3'b100;
  parameter logic [2:0] F3_SR  = 3'b101; // srl/sra
  parameter logic [2:0] F3_OR  = 3'b110;
  parameter logic [2:0] F3_AND = 3'b111;
  parameter logic [2:0] F3_BEQ = 3'b000;
  parameter logic [2:0] F3_BNE = 3'b001;

  parameter insn_t NOP_INSN = {25'd0, OPC_OP_IMM}; // addi x0,x0,0

  //////////////////////////////////////////////////////////////////////
  // compressed formats, msb first
  //////////////////////////////////////////////////////////////////////
  typedef struct packed {
    logic [2:0] funct3; logic imm_hi; logic [4:0] rd; logic [4:0] imm_lo; logic [1:0] op;
  } rvc_ci_t;
  typedef struct packed {
    logic [2:0] funct3; logic [5:0] imm; logic [4:0] rs2; logic [1:0] op;
  } rvc_css_t;
  typedef struct packed {
    logic [2:0] funct3; logic [7:0] imm; logic [2:0] rdp; logic [1:0] op;
  } rvc_ciw_t;
  typedef struct packed {
    logic [2:0] funct3; logic [2:0] imm_hi; logic [2:0] rs1p;
    logic [1:0] imm_lo; logic [2:0] rdp; logic [1:0] op;
  } rvc_cl_t;
  typedef struct packed {
    logic [2:0] funct3; logic [2:0] imm_hi; logic [2:0] rs1p;
    logic [1:0] imm_lo; logic [2:0] rs2p; logic [1:0] op;  // also CA (imm_lo is funct2)
  } rvc_cs_t;
  typedef struct packed {
    logic [2:0] funct3; logic [2:0] off_hi; logic [2:0] rs1p; logic [4:0] off_lo;
    logic [1:0] op;
  } rvc_cb_t;
  typedef struct packed {
    logic [2:0] funct3; logic [10:0] target; logic [1:0] op;
  } rvc_cj_t;
  typedef struct packed {
    logic [3:0] funct4; logic [4:0] rd; logic [4:0] rs2; logic [1:0] op;
  } rvc_cr_t;

  // one parcel, many views
  typedef union packed {
    rvc_ci_t  ci;
    rvc_css_t css;
    rvc_ciw_t ciw;
    rvc_cl_t  cl;
    rvc_cs_t  cs;
    rvc_cb_t  cb;
    rvc_cj_t  cj;
    rvc_cr_t  cr;
  } rvc_parcel_t;

endpackage

`default_nettype wire

// ==== list.f ====
common/fetch_pkg.sv
src/fetch_addr_gen.sv
parcel_queue/parcel_queue.sv
rvc_expand/rvc_expander.sv
src/fetch_out_stage.sv
src/instr_fetch.sv
tests/instr_fetch_tb.sv

// ==== parcel_queue/parcel_queue.sv ====
`timescale 1ns/1ps
`default_nettype none
//////////////////////////////////////////////////////////////////////
// parcel shift queue with per parcel error tags
// almost full keeps room for words still in flight
//////////////////////////////////////////////////////////////////////

module parcel_queue #(
  parameter int QUEUE_PARCELS = 12
)
(
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  logic                                    flush_i,
  input  logic                                    wr_valid_i,
  input  logic [fetch_pkg::XLEN-1:0]              wr_word_i,
  input  logic [fetch_pkg::PARCELS_PER_WORD-1:0]  wr_parcel_valid_i,
  input  logic                                    wr_error_i,
  input  logic [1:0]                              pop_i,
  output fetch_pkg::parcel_t [1:0]                head_parcels_o,
  output logic [1:0]                              head_error_o,
  output logic [1:0]                              avail_o,
  output logic                                    almost_full_o
);

  localparam int PW       = fetch_pkg::PARCEL_W;
  localparam int CNT_W    = $clog2(QUEUE_PARCELS + 1);
  localparam int RESERVE  = 3 * fetch_pkg::PARCELS_PER_WORD;   // 3 words in flight

  logic [QUEUE_PARCELS*PW-1:0] q_data;    // entry 0 is the head
  logic [QUEUE_PARCELS*PW-1:0] nxt_data;
  logic [QUEUE_PARCELS-1:0]    q_err;
  logic [QUEUE_PARCELS-1:0]    nxt_err;
  logic [CNT_W-1:0]            count;
  logic [CNT_W-1:0]            base;      // fill level after pop
  logic [1:0]                  in_cnt;
  fetch_pkg::parcel_t          in_p0;
  fetch_pkg::parcel_t          in_p1;

  // compact the valid halves of the incoming word
  assign in_p0  = wr_parcel_valid_i[0] ? wr_word_i[PW-1:0] : wr_word_i[2*PW-1:PW];
  assign in_p1  = wr_word_i[2*PW-1:PW];
  assign in_cnt = {1'b0, wr_parcel_valid_i[0]} + {1'b0, wr_parcel_valid_i[1]};
  assign base   = count - CNT_W'(pop_i);

  always_comb
  begin
    nxt_data = q_data >> (pop_i * PW);  // drop popped parcels
    nxt_err  = q_err >> pop_i;
    for (int i = 0; i < QUEUE_PARCELS; i++)
    begin
      if (wr_valid_i && in_cnt != 2'd0 && i == base)
      begin
        nxt_data[i*PW +: PW] = in_p0;
        nxt_err[i]           = wr_error_i;
      end
      if (wr_valid_i && in_cnt == 2'd2 && i == base + 1)
      begin
        nxt_data[i*PW +: PW] = in_p1;
        nxt_err[i]           = wr_error_i;
      end
    end
  end

  // payload
  always_ff @(posedge clk_i)
  begin
    q_data <= nxt_data;
    q_err  <= nxt_err;
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      count <= '0;
    else if (flush_i)
      count <= '0;                       // stale responses are dropped too
    else
      count <= base + (wr_valid_i ? CNT_W'(in_cnt) : '0);
  end

  assign head_parcels_o = q_data[2*PW-1:0];
  assign head_error_o   = q_err[1:0];
  assign avail_o        = (count >= CNT_W'(2)) ? 2'd2 : count[1:0];  // capped at 2
  assign almost_full_o  = count >= CNT_W'(QUEUE_PARCELS - RESERVE);

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the fetch front end testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f list.f --top-module instr_fetch_tb \
  --Mdir obj_dir -o vsim \
  && ./obj_dir/vsim | tee /dev/stderr | grep "All tests passed" > /dev/null \
  && exit 0 \
  || exit 1

// ==== rvc_expand/rvc_expander.sv ====
`timescale 1ns/1ps
`default_nettype none
//////////////////////////////////////////////////////////////////////
// RV32C to RV32I expansion, flags reserved and RV64 only encodings
//////////////////////////////////////////////////////////////////////

module rvc_expander (
  input  fetch_pkg::rvc_parcel_t parcel_i,
  output fetch_pkg::insn_t       insn_o,
  output logic                   illegal_o
);

  //////////////////////////////////////////////////////////////////////
  // encoders
  //////////////////////////////////////////////////////////////////////
  function automatic fetch_pkg::insn_t enc_i(logic [11:0] imm, logic [4:0] rs1,
                                             logic [2:0] f3, logic [4:0] rd, logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic fetch_pkg::insn_t enc_s(logic [11:0] imm, logic [4:0] rs2,
                                             logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, fetch_pkg::F3_W, imm[4:0], fetch_pkg::OPC_STORE};
  endfunction

  function automatic fetch_pkg::insn_t enc_b(logic [12:0] imm, logic [4:0] rs1, logic [2:0] f3);
    return {imm[12], imm[10:5], 5'd0, rs1, f3, imm[4:1], imm[11], fetch_pkg::OPC_BRANCH};
  endfunction

  function automatic fetch_pkg::insn_t enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                             logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, fetch_pkg::OPC_OP};
  endfunction

  logic [4:0]       rd_f;       // bits 11:7 (ci, cr)
  logic [4:0]       rs2_f;      // bits 6:2 (css, cr)
  logic [4:0]       rs1_p;      // x8..x15 from bits 9:7
  logic [4:0]       rd_p;       // x8..x15 from bits 4:2
  logic [11:0]      imm_ci;
  logic [11:0]      imm_ciw;
  logic [11:0]      imm_clw;
  logic [11:0]      imm_16sp;
  logic [11:0]      imm_lwsp;
  logic [11:0]      imm_swsp;
  logic [12:0]      imm_cb;
  logic [20:0]      imm_cj;
  logic [19:0]      imm_lui;
  fetch_pkg::insn_t insn;
  logic             ok;

  assign rd_f  = parcel_i.ci.rd;
  assign rs2_f = parcel_i.cr.rs2;
  assign rs1_p = {2'b01, parcel_i.cl.rs1p};
  assign rd_p  = {2'b01, parcel_i.cl.rdp};

  // immediates, unscrambled
  assign imm_ci   = {{6{parcel_i.ci.imm_hi}}, parcel_i.ci.imm_hi, parcel_i.ci.imm_lo};
  assign imm_lui  = {{14{parcel_i.ci.imm_hi}}, parcel_i.ci.imm_hi, parcel_i.ci.imm_lo};
  assign imm_ciw  = {2'b00, parcel_i.ciw.imm[5:2], parcel_i.ciw.imm[7:6],
                     parcel_i.ciw.imm[0], parcel_i.ciw.imm[1], 2'b00};
  assign imm_clw  = {5'd0, parcel_i.cl.imm_lo[0], parcel_i.cl.imm_hi, parcel_i.cl.imm_lo[1],
                     2'b00};
  assign imm_16sp = {{3{parcel_i.ci.imm_hi}}, parcel_i.ci.imm_lo[2:1], parcel_i.ci.imm_lo[3],
                     parcel_i.ci.imm_lo[0], parcel_i.ci.imm_lo[4], 4'd0};
  assign imm_lwsp = {4'd0, parcel_i.ci.imm_lo[1:0], parcel_i.ci.imm_hi, parcel_i.ci.imm_lo[4:2],
                     2'b00};
  assign imm_swsp = {4'd0, parcel_i.css.imm[1:0], parcel_i.css.imm[5:2], 2'b00};
  assign imm_cb   = {{5{parcel_i.cb.off_hi[2]}}, parcel_i.cb.off_lo[4:3], parcel_i.cb.off_lo[0],
                     parcel_i.cb.off_hi[1:0], parcel_i.cb.off_lo[2:1], 1'b0};
  assign imm_cj   = {{10{parcel_i.cj.target[10]}}, parcel_i.cj.target[6], parcel_i.cj.target[8:7],
                     parcel_i.cj.target[4], parcel_i.cj.target[5], parcel_i.cj.target[0],
                     parcel_i.cj.target[9], parcel_i.cj.target[3:1], 1'b0};

  always_comb
  begin
    ok   = 1'b1;
    insn = fetch_pkg::NOP_INSN;
    case ({parcel_i.cr.op, parcel_i.ci.funct3})      // quadrant, funct3
      5'b00_000:                                      // c.addi4spn
      begin
        insn = enc_i(imm_ciw, 5'd2, fetch_pkg::F3_ADD, rd_p, fetch_pkg::OPC_OP_IMM);
        ok   = |parcel_i.ciw.imm;
      end
      5'b00_010: insn = enc_i(imm_clw, rs1_p, fetch_pkg::F3_W, rd_p, fetch_pkg::OPC_LOAD);
      5'b00_110: insn = enc_s(imm_clw, rd_p, rs1_p);  // c.sw, rs2' in bits 4:2
      5'b01_000:                                      // c.addi, rd=x0 is c.nop
        insn = (rd_f == 5'd0) ? fetch_pkg::NOP_INSN
                              : enc_i(imm_ci, rd_f, fetch_pkg::F3_ADD, rd_f, fetch_pkg::OPC_OP_IMM);
      5'b01_001: insn = {imm_cj[20], imm_cj[10:1], imm_cj[11], imm_cj[19:12], 5'd1,
                         fetch_pkg::OPC_JAL};         // c.jal
      5'b01_010: insn = enc_i(imm_ci, 5'd0, fetch_pkg::F3_ADD, rd_f, fetch_pkg::OPC_OP_IMM);
      5'b01_011:                                      // c.addi16sp / c.lui
      begin
        insn = (rd_f == 5'd2) ? enc_i(imm_16sp, 5'd2, fetch_pkg::F3_ADD, 5'd2,
                                      fetch_pkg::OPC_OP_IMM)
                              : {imm_lui, rd_f, fetch_pkg::OPC_LUI};
        ok   = parcel_i.ci.imm_hi | (|parcel_i.ci.imm_lo);
      end
      5'b01_100:                                      // alu on primed registers
        case (parcel_i.cb.off_hi[1:0])
          2'b00: insn = enc_i({7'd0, imm_ci[4:0]}, rs1_p, fetch_pkg::F3_SR, rs1_p,
                              fetch_pkg::OPC_OP_IMM);
          2'b01: insn = enc_i({7'b0100000, imm_ci[4:0]}, rs1_p, fetch_pkg::F3_SR, rs1_p,
                              fetch_pkg::OPC_OP_IMM);
          2'b10: insn = enc_i(imm_ci, rs1_p, fetch_pkg::F3_AND, rs1_p, fetch_pkg::OPC_OP_IMM);
          default:
          begin
            ok = ~parcel_i.cs.imm_hi[2];              // subw/addw are rv64 only
            case (parcel_i.cs.imm_lo)
              2'b00:   insn = enc_r(7'b0100000, rd_p, rs1_p, fetch_pkg::F3_ADD, rs1_p);
              2'b01:   insn = enc_r(7'd0, rd_p, rs1_p, fetch_pkg::F3_XOR, rs1_p);
              2'b10:   insn = enc_r(7'd0, rd_p, rs1_p, fetch_pkg::F3_OR, rs1_p);
              default: insn = enc_r(7'd0, rd_p, rs1_p, fetch_pkg::F3_AND, rs1_p);
            endcase
          end
        endcase
      5'b01_101: insn = {imm_cj[20], imm_cj[10:1], imm_cj[11], imm_cj[19:12], 5'd0,
                         fetch_pkg::OPC_JAL};         // c.j
      5'b01_110: insn = enc_b(imm_cb, rs1_p, fetch_pkg::F3_BEQ);
      5'b01_111: insn = enc_b(imm_cb, rs1_p, fetch_pkg::F3_BNE);
      5'b10_000: insn = enc_i({7'd0, imm_ci[4:0]}, rd_f, fetch_pkg::F3_SLL, rd_f,
                              fetch_pkg::OPC_OP_IMM);
      5'b10_010:                                      // c.lwsp
      begin
        insn = enc_i(imm_lwsp, 5'd2, fetch_pkg::F3_W, rd_f, fetch_pkg::OPC_LOAD);
        ok   = rd_f != 5'd0;
      end
      5'b10_100:                                      // jr/mv/ebreak/jalr/add
      begin
        if (rs2_f != 5'd0)
          insn = enc_r(7'd0, rs2_f, parcel_i.cr.funct4[0] ? rd_f : 5'd0, fetch_pkg::F3_ADD, rd_f);
        else if (parcel_i.cr.funct4[0] && rd_f == 5'd0)
          insn = {11'd0, 1'b1, 13'd0, fetch_pkg::OPC_SYSTEM};
        else
          insn = enc_i(12'd0, rd_f, fetch_pkg::F3_ADD, {4'd0, parcel_i.cr.funct4[0]},
                       fetch_pkg::OPC_JALR);
        ok = parcel_i.cr.funct4[0] | (rs2_f != 5'd0) | (rd_f != 5'd0);  // c.jr x0 reserved
      end
      5'b10_110: insn = enc_s(imm_swsp, parcel_i.css.rs2, 5'd2);
      default:   ok = 1'b0;                           // fp, rv64 only, reserved, quadrant 3
    endcase
  end

  assign illegal_o = ~ok;
  assign insn_o    = ok ? insn : {{(fetch_pkg::XLEN-fetch_pkg::PARCEL_W){1'b0}}, parcel_i};

endmodule

`default_nettype wire

// ==== src/fetch_addr_gen.sv ====
`timescale 1ns/1ps
`default_nettype none
//////////////////////////////////////////////////////////////////////
// fetch address register, memory request and flush
//////////////////////////////////////////////////////////////////////

module fetch_addr_gen #(
  parameter logic [fetch_pkg::XLEN-1:0] PC_INIT = '0
)
(
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      redirect_i,
  input  logic [fetch_pkg::XLEN-1:0] redirect_pc_i,
  input  logic                      imem_ack_i,
  input  logic                      almost_full_i,
  output logic                      imem_req_o,
  output logic [fetch_pkg::XLEN-1:0] imem_adr_o,
  output logic                      flush_o
);

  localparam logic [fetch_pkg::XLEN-1:0] WORD_MASK = {{(fetch_pkg::XLEN-2){1'b1}}, 2'b00};

  logic [fetch_pkg::XLEN-1:0] fetch_adr;

  assign flush_o    = redirect_i;                   // single cycle, like the redirect
  assign imem_req_o = ~almost_full_i & ~flush_o;    // hold off while queue nearly full
  assign imem_adr_o = fetch_adr;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      fetch_adr <= PC_INIT;
    else if (redirect_i)
      fetch_adr <= redirect_pc_i;                   // may sit on an odd half word
    else if (imem_req_o && imem_ack_i)
      fetch_adr <= (fetch_adr + 'd4) & WORD_MASK;   // next word boundary
  end

endmodule

`default_nettype wire

// ==== src/fetch_out_stage.sv ====
`timescale 1ns/1ps
`default_nettype none
//////////////////////////////////////////////////////////////////////
// length decode, queue pop, pc tracking and decode output register
//////////////////////////////////////////////////////////////////////

module fetch_out_stage #(
  parameter logic [fetch_pkg::XLEN-1:0] PC_INIT = '0
)
(
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       redirect_i,
  input  logic [fetch_pkg::XLEN-1:0] redirect_pc_i,
  input  fetch_pkg::parcel_t [1:0]   head_parcels_i,
  input  logic [1:0]                 head_error_i,
  input  logic [1:0]                 avail_i,
  input  logic                       out_ready_i,
  output logic [1:0]                 pop_o,
  output logic                       out_valid_o,
  output logic [fetch_pkg::XLEN-1:0] out_pc_o,
  output fetch_pkg::insn_t           out_insn_o,
  output logic                       out_illegal_o,
  output logic                       out_fault_o
);

  logic [fetch_pkg::XLEN-1:0] pc_q;        // pc of the instruction at the queue head
  fetch_pkg::insn_t           rv_insn;
  logic                       rvc_illegal;
  logic                       is_rvc;
  logic                       have_insn;
  logic                       load;

  rvc_expander u_rvc_expander (
    .parcel_i  ( fetch_pkg::rvc_parcel_t'(head_parcels_i[0]) ),
    .insn_o    ( rv_insn                                      ),
    .illegal_o ( rvc_illegal                                  )
  );

  assign is_rvc    = head_parcels_i[0][1:0] != 2'b11;
  assign have_insn = is_rvc ? (avail_i != 2'd0) : (avail_i == 2'd2);
  assign load      = have_insn & (~out_valid_o | out_ready_i) & ~redirect_i;  // empty or draining
  assign pop_o     = !load ? 2'd0 : (is_rvc ? 2'd1 : 2'd2);

  ////////////////////////////////////////////////////////////////////
  // output register
  ////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      pc_q          <= PC_INIT;
      out_valid_o   <= 1'b0;
      out_pc_o      <= PC_INIT;
      out_insn_o    <= fetch_pkg::NOP_INSN;
      out_illegal_o <= 1'b0;
      out_fault_o   <= 1'b0;
    end
    else if (redirect_i)
    begin
      pc_q        <= redirect_pc_i;
      out_valid_o <= 1'b0;           // drop whatever was waiting
    end
    else if (load)
    begin
      pc_q          <= pc_q + (is_rvc ? 'd2 : 'd4);
      out_valid_o   <= 1'b1;
      out_pc_o      <= pc_q;
      out_insn_o    <= is_rvc ? rv_insn : {head_parcels_i[1], head_parcels_i[0]};
      out_illegal_o <= is_rvc & rvc_illegal;
      out_fault_o   <= head_error_i[0] | (~is_rvc & head_error_i[1]);  // parcels used only
    end
    else if (out_ready_i)
      out_valid_o <= 1'b0;
  end

endmodule

`default_nettype wire

// ==== src/instr_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none
//////////////////////////////////////////////////////////////////////
// instruction fetch front end top level
// address generator, parcel queue and output stage
//////////////////////////////////////////////////////////////////////

module instr_fetch #(
  parameter logic [fetch_pkg::XLEN-1:0] PC_INIT       = 32'h0000_0200,
  parameter int                         QUEUE_PARCELS = 12
)
(
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  output logic                                   imem_req_o,
  output logic [fetch_pkg::XLEN-1:0]             imem_adr_o,
  input  logic                                   imem_ack_i,
  output logic                                   imem_flush_o,
  input  logic                                   imem_rvalid_i,
  input  logic [fetch_pkg::XLEN-1:0]             imem_word_i,
  input  logic [fetch_pkg::PARCELS_PER_WORD-1:0] imem_parcel_valid_i,
  input  logic                                   imem_error_i,
  input  logic                                   redirect_i,
  input  logic [fetch_pkg::XLEN-1:0]             redirect_pc_i,
  output logic                                   out_valid_o,
  input  logic                                   out_ready_i,
  output logic [fetch_pkg::XLEN-1:0]             out_pc_o,
  output fetch_pkg::insn_t                       out_insn_o,
  output logic                                   out_illegal_o,
  output logic                                   out_fault_o
);

  logic                     almost_full;
  fetch_pkg::parcel_t [1:0] head_parcels;
  logic [1:0]               head_error;
  logic [1:0]               avail;
  logic [1:0]               pop;

  fetch_addr_gen #(
    .PC_INIT ( PC_INIT )
  ) u_addr_gen (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .redirect_i    ( redirect_i    ),
    .redirect_pc_i ( redirect_pc_i ),
    .imem_ack_i    ( imem_ack_i    ),
    .almost_full_i ( almost_full   ),
    .imem_req_o    ( imem_req_o    ),
    .imem_adr_o    ( imem_adr_o    ),
    .flush_o       ( imem_flush_o  )   // memory and queue together
  );

  parcel_queue #(
    .QUEUE_PARCELS ( QUEUE_PARCELS )
  ) u_parcel_queue (
    .clk_i             ( clk_i               ),
    .rst_ni            ( rst_ni              ),
    .flush_i           ( imem_flush_o        ),
    .wr_valid_i        ( imem_rvalid_i       ),
    .wr_word_i         ( imem_word_i         ),
    .wr_parcel_valid_i ( imem_parcel_valid_i ),
    .wr_error_i        ( imem_error_i        ),
    .pop_i             ( pop                 ),
    .head_parcels_o    ( head_parcels        ),
    .head_error_o      ( head_error          ),
    .avail_o           ( avail               ),
    .almost_full_o     ( almost_full         )
  );

  fetch_out_stage #(
    .PC_INIT ( PC_INIT )
  ) u_out_stage (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .redirect_i     ( redirect_i     ),
    .redirect_pc_i  ( redirect_pc_i  ),
    .head_parcels_i ( head_parcels   ),
    .head_error_i   ( head_error     ),
    .avail_i        ( avail          ),
    .out_ready_i    ( out_ready_i    ),
    .pop_o          ( pop            ),
    .out_valid_o    ( out_valid_o    ),
    .out_pc_o       ( out_pc_o       ),
    .out_insn_o     ( out_insn_o     ),
    .out_illegal_o  ( out_illegal_o  ),
    .out_fault_o    ( out_fault_o    )
  );

endmodule

`default_nettype wire

// ==== tests/fetch_cases.txt ====
// columns flags_field1_field2: memory at @00 is err_0_word, redirects at @10 are 0_count_target
// expected stream at @14 is flags_pc_insn, flags bit1 illegal and bit0 fault
@00
0_00000000_00a00093
0_00000000_002081b3
0_00000000_157d4515
0_00000000_22830001
0_00000000_85aa0081
0_00000000_40020000
0_00000000_80029c25
1_00000000_00108093
0_00000000_00934515
1_00000000_000100a0
0_00000000_00000013
0_00000000_ffffffff
0_00000000_4515ffff
0_00000000_00a00093
@10
0_0000000f_00000232
0_00000011_0000020e
@14
0_00000200_00a00093
0_00000204_002081b3
0_00000208_00500513
0_0000020a_fff50513
0_0000020c_00000013
0_0000020e_00812283
0_00000212_00a005b3
2_00000214_00000000
2_00000216_00004002
2_00000218_00009c25
2_0000021a_00008002
1_0000021c_00108093
0_00000220_00500513
1_00000222_00a00093
1_00000226_00000013
0_00000232_00500513
0_00000234_00a00093
0_0000020e_00812283
0_00000212_00a005b3
2_00000214_00000000

// ==== tests/instr_fetch_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
//////////////////////////////////////////////////////////////////////
// testbench for the instruction fetch front end
// memory model, redirect and back-pressure driver, stream checker
//////////////////////////////////////////////////////////////////////

module instr_fetch_tb;

  localparam logic [31:0] PC_INIT   = 32'h0000_0200;
  localparam int          MEM_WORDS = 16;
  localparam int          RDR_BASE  = 16;    // redirect list
  localparam int          RDR_MAX   = 4;
  localparam int          EXP_BASE  = 20;    // expected stream
  localparam int          CASE_LEN  = 64;
  localparam logic [67:0] END_MARK  = '1;

  logic        clk_i;
  logic        rst_ni;
  logic        imem_req_o;
  logic [31:0] imem_adr_o;
  logic        imem_ack_i;
  logic        imem_flush_o;
  logic        imem_rvalid_i;
  logic [31:0] imem_word_i;
  logic [1:0]  imem_parcel_valid_i;
  logic        imem_error_i;
  logic        redirect_i;
  logic [31:0] redirect_pc_i;
  logic        out_valid_o;
  logic        out_ready_i;
  logic [31:0] out_pc_o;
  logic [31:0] out_insn_o;
  logic        out_illegal_o;
  logic        out_fault_o;

  logic [67:0] cases [CASE_LEN];
  logic [31:0] pend_adr [$];     // accepted, not yet answered
  int          pend_due [$];
  int          n_checks;
  int          n_errors;

  instr_fetch #(
    .PC_INIT       ( PC_INIT ),
    .QUEUE_PARCELS ( 12      )
  ) UUT (
    .clk_i               ( clk_i               ),
    .rst_ni              ( rst_ni              ),
    .imem_req_o          ( imem_req_o          ),
    .imem_adr_o          ( imem_adr_o          ),
    .imem_ack_i          ( imem_ack_i          ),
    .imem_flush_o        ( imem_flush_o        ),
    .imem_rvalid_i       ( imem_rvalid_i       ),
    .imem_word_i         ( imem_word_i         ),
    .imem_parcel_valid_i ( imem_parcel_valid_i ),
    .imem_error_i        ( imem_error_i        ),
    .redirect_i          ( redirect_i          ),
    .redirect_pc_i       ( redirect_pc_i       ),
    .out_valid_o         ( out_valid_o         ),
    .out_ready_i         ( out_ready_i         ),
    .out_pc_o            ( out_pc_o            ),
    .out_insn_o          ( out_insn_o          ),
    .out_illegal_o       ( out_illegal_o       ),
    .out_fault_o         ( out_fault_o         )
  );

  initial
  begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;   // 4 ns period
  end

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////
  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    n_checks++;
    if (exp !== act)
    begin
      n_errors++;
      $display("FAIL %s expected %h actual %h", name, exp, act);
    end
  endtask

  // 16 bit fibonacci, taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // image word with error flag, address based filler outside the image
  function automatic logic [67:0] mem_word(input logic [31:0] adr);
    logic [31:0] off;
    off = adr - PC_INIT;
    if (off < 32'(MEM_WORDS * 4) && cases[off >> 2] != END_MARK)
      return cases[off >> 2];
    return {36'd0, adr[31:2], 2'b11};
  endfunction

  //////////////////////////////////////////////////////////////////////
  // stimulus and checking
  //////////////////////////////////////////////////////////////////////
  initial
  begin : run
    logic [67:0] e;
    logic [67:0] w;
    logic [31:0] adr;
    logic [15:0] lfsr;
    logic        held;
    logic [31:0] held_pc;
    logic [31:0] held_insn;
    logic        held_ill;
    logic        held_flt;
    int          n_exp;
    int          n_rdr;
    int          rdr_idx;
    int          got;
    int          cyc;
    int          limit;
    rst_ni              = 1'b0;
    imem_ack_i          = 1'b0;
    imem_rvalid_i       = 1'b0;
    imem_word_i         = '0;
    imem_parcel_valid_i = '0;
    imem_error_i        = 1'b0;
    redirect_i          = 1'b0;
    redirect_pc_i       = '0;
    out_ready_i         = 1'b0;
    n_checks            = 0;
    n_errors            = 0;
    lfsr                = 16'd40341;
    held                = 1'b0;
    held_pc             = '0;
    held_insn           = '0;
    held_ill            = 1'b0;
    held_flt            = 1'b0;
    rdr_idx             = 0;
    got                 = 0;
    cyc                 = 0;
    for (int i = 0; i < CASE_LEN; i++)
      cases[i] = END_MARK;
    $readmemh("tests/fetch_cases.txt", cases);
    n_exp = 0;
    while (EXP_BASE + n_exp < CASE_LEN && cases[EXP_BASE + n_exp] != END_MARK)
      n_exp++;
    n_rdr = 0;
    while (n_rdr < RDR_MAX && cases[RDR_BASE + n_rdr] != END_MARK)
      n_rdr++;
    limit = 40 * n_exp;            // cycles allowed per expected entry

    repeat (16) @(negedge clk_i);
    rst_ni = 1'b1;
    #1;
    check_value("reset valid", 32'd0, {31'd0, out_valid_o});
    check_value("reset flush", 32'd0, {31'd0, imem_flush_o});
    check_value("reset req", 32'd1, {31'd0, imem_req_o});
    check_value("reset adr", PC_INIT, imem_adr_o);

    while (got < n_exp)
    begin
      @(negedge clk_i);
      cyc++;
      if (cyc > limit)
      begin
        $display("timeout: %0d of %0d instructions after %0d cycles", got, n_exp, cyc);
        $display("Some tests failed");
        $finish;
      end
      if (held)                    // stalled output must not move
      begin
        check_value("hold valid", 32'd1, {31'd0, out_valid_o});
        check_value("hold pc", held_pc, out_pc_o);
        check_value("hold insn", held_insn, out_insn_o);
        check_value("hold illegal", {31'd0, held_ill}, {31'd0, out_illegal_o});
        check_value("hold fault", {31'd0, held_flt}, {31'd0, out_fault_o});
      end
      lfsr        = lfsr_step(lfsr);
      out_ready_i = lfsr[0];       // random back-pressure
      redirect_i  = 1'b0;
      held        = out_valid_o && !out_ready_i;
      held_pc     = out_pc_o;
      held_insn   = out_insn_o;
      held_ill    = out_illegal_o;
      held_flt    = out_fault_o;
      if (out_valid_o && out_ready_i)
      begin
        e = cases[EXP_BASE + got];
        check_value($sformatf("pc #%0d", got), e[63:32], out_pc_o);
        check_value($sformatf("insn #%0d", got), e[31:0], out_insn_o);
        check_value($sformatf("illegal #%0d", got), {31'd0, e[65]}, {31'd0, out_illegal_o});
        check_value($sformatf("fault #%0d", got), {31'd0, e[64]}, {31'd0, out_fault_o});
        got++;
        if (rdr_idx < n_rdr && cases[RDR_BASE + rdr_idx][63:32] == 32'(got))
        begin
          redirect_i    = 1'b1;    // same edge as the transfer
          redirect_pc_i = cases[RDR_BASE + rdr_idx][31:0];
          rdr_idx++;
        end
      end

      // memory side
      imem_rvalid_i = 1'b0;
      if (redirect_i)
      begin
        pend_adr.delete();         // flush drops everything pending
        pend_due.delete();
      end
      else if (pend_due.size() > 0 && pend_due[0] <= cyc)
      begin
        adr = pend_adr.pop_front();
        void'(pend_due.pop_front());
        w                   = mem_word(adr);
        imem_rvalid_i       = 1'b1;
        imem_word_i         = w[31:0];
        imem_error_i        = w[64];
        imem_parcel_valid_i = adr[1] ? 2'b10 : 2'b11;
      end
      lfsr       = lfsr_step(lfsr);
      imem_ack_i = lfsr[0] && (pend_due.size() + int'(imem_rvalid_i) < 3);  // 3 in flight
      #1;
      check_value("flush", {31'd0, redirect_i}, {31'd0, imem_flush_o});  // one cycle per redirect
      if (imem_flush_o)
        check_value("flush req", 32'd0, {31'd0, imem_req_o});
      if (imem_req_o && imem_ack_i && !imem_flush_o)
      begin
        pend_adr.push_back(imem_adr_o);
        pend_due.push_back(cyc + 2);
      end
    end

    @(negedge clk_i);
    $display("%0d checks, %0d errors, %0d of %0d instructions", n_checks, n_errors, got, n_exp);
    if (n_errors == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire
